/* rtl/dcache_pkg.sv */
package dcache_pkg;

	// address and data geometry
	localparam int ADDR_W = 32;
	localparam int WORD_W = 64;
	localparam int BYTES_PER_WORD = 8;
	localparam int WORDS_PER_LINE = 8;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE; // 512

	// cache organisation
	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 2;

	// address split: tag | index | word select | byte
	localparam int OFFSET_W = 6;
	localparam int INDEX_W = 4;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W; // 22

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

	// word 0 sits in the low bits
	typedef logic [LINE_W-1:0] line_t;

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;
	typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

endpackage

/* rtl/tag_state_array.sv */
module tag_state_array import dcache_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  index_t index,
	input  tag_t   tag,
	input  logic   touch,
	input  logic   fill,
	input  logic   mark_dirty,
	input  way_t   way,
	output logic   hit,
	output way_t   hit_way,
	output way_t   victim_way,
	output logic   victim_dirty,
	output tag_t   victim_tag
);

	tag_t tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_WAYS-1:0] valid [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty [NUM_SETS];
	logic [NUM_WAYS-1:0] lru [NUM_SETS]; // set bit = older way

	logic [NUM_WAYS-1:0] hit_vec;

	// both ways compared in parallel
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_vec[w] = valid[index][w] && (tag_mem[w][index] == tag);
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
		hit = |hit_vec;
	end

	// way 0 goes first while both lru bits are clear
	assign victim_way = way_t'(lru[index][1]);
	assign victim_dirty = valid[index][victim_way] && dirty[index][victim_way];
	assign victim_tag = tag_mem[victim_way][index];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				lru[s] <= '0;
			end
		end else begin
			if (fill) begin
				valid[index][way] <= 1'b1;
				dirty[index][way] <= 1'b0; // fresh line is clean
			end
			if (mark_dirty)
				dirty[index][way] <= 1'b1;
			if (touch || fill) begin
				lru[index][way] <= 1'b0;
				lru[index][~way] <= 1'b1;
			end
		end
	end

	// tag store
	always_ff @(posedge clk) begin
		if (fill)
			tag_mem[way][index] <= tag;
	end

endmodule

/* rtl/line_data_array.sv */
module line_data_array import dcache_pkg::*; (
	input  logic      clk,
	input  index_t    index,
	input  way_t      way,
	input  word_sel_t word_sel,
	input  logic      word_wr,
	input  byte_en_t  be,
	input  word_t     wdata,
	input  logic      line_fill,
	input  line_t     fill_line,
	output word_t     rword,
	output line_t     rline
);

	word_t data_mem [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];

	always_ff @(posedge clk) begin
		if (line_fill) begin
			for (int w = 0; w < WORDS_PER_LINE; w++)
				data_mem[way][index][w] <= fill_line[w*WORD_W +: WORD_W];
		end else if (word_wr) begin
			// only enabled bytes land
			for (int b = 0; b < BYTES_PER_WORD; b++) begin
				if (be[b])
					data_mem[way][index][word_sel][b*(WORD_W/BYTES_PER_WORD) +:
						WORD_W/BYTES_PER_WORD] <=
						wdata[b*(WORD_W/BYTES_PER_WORD) +: WORD_W/BYTES_PER_WORD];
			end
		end
	end

	assign rword = data_mem[way][index][word_sel];

	// whole line for write-back
	always_comb begin
		for (int w = 0; w < WORDS_PER_LINE; w++)
			rline[w*WORD_W +: WORD_W] = data_mem[way][index][w];
	end

endmodule

/* rtl/dcache_ctrl.sv */
module dcache_ctrl import dcache_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      req,
	input  logic      we,
	input  addr_t     addr,
	input  word_t     wdata,
	input  byte_en_t  be,
	input  logic      hit,
	input  way_t      hit_way,
	input  way_t      victim_way,
	input  logic      victim_dirty,
	input  tag_t      victim_tag,
	input  word_t     rword,
	input  line_t     rline,
	input  logic      mem_rvalid,
	input  line_t     mem_rline,
	input  logic      mem_wdone,
	output logic      busy,
	output logic      done,
	output logic      hit_out,
	output word_t     rdata,
	output index_t    index,
	output tag_t      tag,
	output word_sel_t word_sel,
	output way_t      way,
	output logic      touch,
	output logic      fill,
	output logic      mark_dirty,
	output logic      word_wr,
	output byte_en_t  word_be,
	output word_t     word_data,
	output logic      line_fill,
	output line_t     fill_line,
	output logic      mem_rd,
	output logic      mem_wr,
	output addr_t     mem_addr,
	output line_t     mem_wline
);

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITE_BACK,
		REFILL,
		INSTALL,
		COMPLETE
	} state_t;

	state_t state;

	// request held for the whole access
	logic     we_r;
	addr_t    addr_r;
	word_t    wdata_r;
	byte_en_t be_r;
	way_t     way_r;
	line_t    fill_buf;
	addr_t    line_addr;

	assign index = addr_r[OFFSET_W +: INDEX_W];
	assign tag = addr_r[ADDR_W-1 -: TAG_W];
	assign word_sel = addr_r[OFFSET_W-1:$clog2(BYTES_PER_WORD)];
	assign line_addr = {addr_r[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	assign way = way_r;

	assign busy = (state != IDLE);
	assign done = (state == COMPLETE);
	assign rdata = rword;

	assign fill = (state == INSTALL);
	assign line_fill = (state == INSTALL);
	assign fill_line = fill_buf;
	assign touch = (state == COMPLETE); // every access refreshes lru
	assign word_wr = (state == COMPLETE) && we_r;
	assign mark_dirty = (state == COMPLETE) && we_r;
	assign word_be = be_r;
	assign word_data = wdata_r;
	assign mem_wline = rline; // victim line, way_r frozen at lookup

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
			hit_out <= 1'b0;
		end else begin
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
			case (state)
				IDLE: if (req) state <= LOOKUP;
				LOOKUP: begin
					hit_out <= hit;
					if (hit) begin
						state <= COMPLETE;
					end else if (victim_dirty) begin
						mem_wr <= 1'b1; // evict first
						state <= WRITE_BACK;
					end else begin
						mem_rd <= 1'b1;
						state <= REFILL;
					end
				end
				WRITE_BACK: if (mem_wdone) begin
					mem_rd <= 1'b1;
					state <= REFILL;
				end
				REFILL: if (mem_rvalid) state <= INSTALL;
				INSTALL: state <= COMPLETE;
				COMPLETE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			we_r <= we;
			addr_r <= addr;
			wdata_r <= wdata;
			be_r <= be;
		end
		if (state == LOOKUP) begin
			way_r <= hit ? hit_way : victim_way;
			if (!hit && victim_dirty)
				mem_addr <= {victim_tag, index, {OFFSET_W{1'b0}}};
			else
				mem_addr <= line_addr;
		end
		if (state == WRITE_BACK && mem_wdone)
			mem_addr <= line_addr; // now fetch the missing line
		if (state == REFILL && mem_rvalid)
			fill_buf <= mem_rline;
	end

endmodule

/* rtl/dcache_top.sv */
module dcache_top import dcache_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     req,
	input  logic     we,
	input  addr_t    addr,
	input  word_t    wdata,
	input  byte_en_t be,
	input  logic     mem_rvalid,
	input  line_t    mem_rline,
	input  logic     mem_wdone,
	output logic     busy,
	output logic     done,
	output logic     hit,
	output word_t    rdata,
	output logic     mem_rd,
	output logic     mem_wr,
	output addr_t    mem_addr,
	output line_t    mem_wline
);

	index_t    index;
	tag_t      tag;
	word_sel_t word_sel;
	way_t      way;
	logic      touch, fill, mark_dirty;
	logic      lookup_hit;
	way_t      hit_way, victim_way;
	logic      victim_dirty;
	tag_t      victim_tag;
	logic      word_wr, line_fill;
	byte_en_t  word_be;
	word_t     word_data, rword;
	line_t     fill_line, rline;

	dcache_ctrl ctrl (
		.clk, .reset, .req, .we, .addr, .wdata, .be,
		.hit(lookup_hit), .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.rword, .rline, .mem_rvalid, .mem_rline, .mem_wdone,
		.busy, .done, .hit_out(hit), .rdata, .index, .tag, .word_sel, .way,
		.touch, .fill, .mark_dirty, .word_wr, .word_be, .word_data,
		.line_fill, .fill_line, .mem_rd, .mem_wr, .mem_addr, .mem_wline
	);

	tag_state_array tags (
		.clk, .reset, .index, .tag, .touch, .fill, .mark_dirty, .way,
		.hit(lookup_hit), .hit_way, .victim_way, .victim_dirty, .victim_tag
	);

	line_data_array lines (
		.clk, .index, .way, .word_sel, .word_wr, .be(word_be), .wdata(word_data),
		.line_fill, .fill_line, .rword, .rline
	);

endmodule

/* testbench/dcache_assertions.sv */
module dcache_assertions (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic mem_rd,
	input logic mem_wr,
	input logic mem_rvalid,
	input logic mem_wdone
);

	timeunit 1ns;
	timeprecision 100ps;

	logic mem_pending; // strobe sent, reply not seen yet

	always_ff @(posedge clk) begin
		if (reset)
			mem_pending <= 1'b0;
		else if (mem_rvalid || mem_wdone)
			mem_pending <= 1'b0;
		else if (mem_rd || mem_wr)
			mem_pending <= 1'b1;
	end

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset) !(mem_rd && mem_wr))
		else $error("mem_rd and mem_wr high in the same cycle");

	done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done high for more than one cycle");

	done_in_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
		else $error("done while busy is low");

	one_outstanding: assert property (@(posedge clk) disable iff (reset)
		mem_pending |-> !(mem_rd || mem_wr))
		else $error("new memory strobe while a reply is outstanding");

endmodule

/* testbench/tb_dcache.sv */
module tb_dcache import dcache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 100;
	localparam int RANDOM_OPS = 300;

	logic clk = 1'b0;
	logic reset, req, we, mem_rvalid, mem_wdone;
	addr_t addr;
	word_t wdata;
	byte_en_t be;
	line_t mem_rline;
	logic busy, done, hit, mem_rd, mem_wr;
	word_t rdata;
	addr_t mem_addr;
	line_t mem_wline;

	word_t image [addr_t]; // every processor write applied
	word_t mem_store [addr_t];
	tag_t ref_tag [NUM_SETS][NUM_WAYS];
	logic ref_valid [NUM_SETS][NUM_WAYS];
	logic ref_dirty [NUM_SETS][NUM_WAYS];
	way_t ref_victim [NUM_SETS];

	string name_q [$];
	logic hit_q [$];
	word_t word_q [$];
	logic we_q [$];
	addr_t wb_q [$];
	addr_t cur_line;
	logic timed_out = 1'b0;
	int errors = 0;
	int checks = 0;

	dcache_top UUT (
		.clk, .reset, .req, .we, .addr, .wdata, .be, .mem_rvalid, .mem_rline, .mem_wdone,
		.busy, .done, .hit, .rdata, .mem_rd, .mem_wr, .mem_addr, .mem_wline
	);

	bind dcache_top dcache_assertions protocol_checks (
		.clk, .reset, .busy, .done, .mem_rd, .mem_wr, .mem_rvalid, .mem_wdone
	);

	always #2 clk = ~clk;

	function automatic word_t pattern_word(addr_t a);
		return {a ^ 32'h9e37_79b9, ~{a[15:0], a[31:16]}};
	endfunction

	function automatic addr_t make_addr(tag_t t, index_t i, word_sel_t w);
		return {t, i, w, 3'b000};
	endfunction

	function automatic word_t image_word(addr_t a);
		return image.exists(a) ? image[a] : pattern_word(a);
	endfunction

	function automatic word_t stored_word(addr_t a);
		return mem_store.exists(a) ? mem_store[a] : pattern_word(a);
	endfunction

	function automatic line_t build_line(addr_t base, logic from_image);
		line_t l;
		addr_t wa;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			wa = {base[ADDR_W-1:OFFSET_W], word_sel_t'(w), 3'b000};
			l[w*WORD_W +: WORD_W] = from_image ? image_word(wa) : stored_word(wa);
		end
		return l;
	endfunction

	// expected hit, read word and eviction for one access
	function automatic void ref_access(input logic wr, input addr_t a, input word_t wd,
			input byte_en_t b, output logic exp_hit, output word_t exp_word,
			output logic wb, output addr_t wb_addr);
		index_t idx;
		tag_t t;
		way_t w;
		addr_t wa;
		word_t merged;
		idx = a[OFFSET_W +: INDEX_W];
		t = a[ADDR_W-1 -: TAG_W];
		wa = {a[ADDR_W-1:3], 3'b000};
		w = ref_victim[idx];
		exp_hit = 1'b0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (ref_valid[idx][i] && ref_tag[idx][i] == t) begin
				exp_hit = 1'b1;
				w = way_t'(i);
			end
		end
		wb = !exp_hit && ref_valid[idx][w] && ref_dirty[idx][w];
		wb_addr = {ref_tag[idx][w], idx, {OFFSET_W{1'b0}}};
		if (!exp_hit) begin
			ref_tag[idx][w] = t;
			ref_valid[idx][w] = 1'b1;
			ref_dirty[idx][w] = 1'b0;
		end
		exp_word = image_word(wa);
		if (wr) begin
			merged = exp_word;
			for (int k = 0; k < BYTES_PER_WORD; k++)
				if (b[k]) merged[k*8 +: 8] = wd[k*8 +: 8];
			image[wa] = merged;
			ref_dirty[idx][w] = 1'b1;
		end
		ref_victim[idx] = ~w; // other way is now the older one
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_hit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected hit %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected busy %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout: %s", what);
	endtask

	task automatic run_access(input string name, input logic wr, input addr_t a,
			input word_t wd, input byte_en_t b, output int lat);
		logic exp_hit;
		logic wb;
		word_t exp_word;
		addr_t wb_addr;
		int n;
		lat = 0;
		n = 0;
		while (busy && !timed_out) begin
			@(posedge clk);
			#1;
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("busy stayed high");
		end
		if (!timed_out) begin
			ref_access(wr, a, wd, b, exp_hit, exp_word, wb, wb_addr);
			name_q.push_back(name);
			hit_q.push_back(exp_hit);
			word_q.push_back(exp_word);
			we_q.push_back(wr);
			if (wb)
				wb_q.push_back(wb_addr);
			cur_line = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
			req = 1'b1;
			we = wr;
			addr = a;
			wdata = wd;
			be = b;
			do begin
				@(posedge clk);
				#1;
				req = 1'b0;
				lat++;
				check_busy(name, 1'b1, busy); // up to and including done
				if (lat > WAIT_LIMIT)
					report_timeout("no done for a request");
			end while (!done && !timed_out);
		end
	endtask

	// memory side, random reply delay
	initial begin : memory_model
		int delay;
		addr_t wb_addr;
		mem_rvalid = 1'b0;
		mem_wdone = 1'b0;
		mem_rline = '0;
		@(posedge clk);
		#1;
		forever begin
			if (mem_wr === 1'b1) begin
				if (wb_q.size() == 0) begin
					errors++;
					$display("unexpected write-back to %h", mem_addr);
				end else begin
					wb_addr = wb_q.pop_front();
					check_addr("write-back address", wb_addr, mem_addr);
					check_line("write-back line", build_line(wb_addr, 1'b1), mem_wline);
				end
				for (int w = 0; w < WORDS_PER_LINE; w++)
					mem_store[{mem_addr[ADDR_W-1:OFFSET_W], word_sel_t'(w), 3'b000}] =
						mem_wline[w*WORD_W +: WORD_W];
				delay = $urandom_range(6, 2);
				repeat (delay) @(posedge clk);
				#1;
				mem_wdone = 1'b1;
				@(posedge clk);
				#1;
				mem_wdone = 1'b0;
				checks++;
				if (mem_rd !== 1'b1) begin
					errors++;
					$display("mem_rd did not follow mem_wdone");
				end
			end else if (mem_rd === 1'b1) begin
				check_addr("refill address", cur_line, mem_addr);
				delay = $urandom_range(6, 2);
				repeat (delay) @(posedge clk);
				#1;
				mem_rline = build_line(mem_addr, 1'b0);
				mem_rvalid = 1'b1;
				@(posedge clk);
				#1;
				mem_rvalid = 1'b0;
			end else begin
				@(posedge clk);
				#1;
			end
		end
	end

	initial begin : compare_results
		string name;
		forever begin
			@(posedge clk);
			#1;
			if (done) begin
				if (name_q.size() == 0) begin
					errors++;
					$display("done pulse without a pending request");
				end else begin
					name = name_q.pop_front();
					check_hit(name, hit_q.pop_front(), hit);
					if (we_q.pop_front())
						void'(word_q.pop_front()); // rdata means nothing on a write
					else
						check_word(name, word_q.pop_front(), rdata);
				end
			end
		end
	end

	initial begin
		int lat;
		tag_t t;
		index_t idx;
		void'($urandom(32'ha8da_ca88));
		reset = 1'b1;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		be = '0;
		for (int s = 0; s < NUM_SETS; s++) begin
			ref_victim[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
			end
		end
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		run_access("cold read miss", 1'b0, make_addr(22'h100, 4'd3, 3'd2), '0, '0, lat);
		run_access("read hit", 1'b0, make_addr(22'h100, 4'd3, 3'd5), '0, '0, lat);
		checks++;
		if (lat != 2) begin
			errors++;
			$display("[ERROR] hit latency: expected 2, actual %0d", lat);
		end

		run_access("masked write hit", 1'b1, make_addr(22'h100, 4'd3, 3'd2),
			64'h1122_3344_5566_7788, 8'b1010_0101, lat);
		run_access("masked readback", 1'b0, make_addr(22'h100, 4'd3, 3'd2), '0, '0, lat);
		run_access("neighbour word", 1'b0, make_addr(22'h100, 4'd3, 3'd1), '0, '0, lat);

		// A, B, A, then C must push out B
		run_access("lru fill A", 1'b0, make_addr(22'h011, 4'd7, 3'd0), '0, '0, lat);
		run_access("lru fill B", 1'b0, make_addr(22'h022, 4'd7, 3'd0), '0, '0, lat);
		run_access("lru touch A", 1'b0, make_addr(22'h011, 4'd7, 3'd1), '0, '0, lat);
		run_access("lru evict B", 1'b0, make_addr(22'h033, 4'd7, 3'd0), '0, '0, lat);
		run_access("lru A kept", 1'b0, make_addr(22'h011, 4'd7, 3'd2), '0, '0, lat);
		run_access("lru B gone", 1'b0, make_addr(22'h022, 4'd7, 3'd3), '0, '0, lat);

		run_access("dirty write", 1'b1, make_addr(22'h044, 4'd9, 3'd6),
			{$urandom, $urandom}, 8'hff, lat);
		run_access("fill other way", 1'b0, make_addr(22'h055, 4'd9, 3'd0), '0, '0, lat);
		run_access("evict dirty line", 1'b0, make_addr(22'h066, 4'd9, 3'd0), '0, '0, lat);
		checks++;
		if (wb_q.size() != 0) begin
			errors++;
			$display("the expected write-back of a dirty line did not occur");
		end
		run_access("refetch written line", 1'b0, make_addr(22'h044, 4'd9, 3'd6), '0, '0, lat);

		run_access("write miss", 1'b1, make_addr(22'h077, 4'd12, 3'd4),
			64'hdead_beef_0bad_f00d, 8'hf0, lat);
		run_access("merged read", 1'b0, make_addr(22'h077, 4'd12, 3'd4), '0, '0, lat);

		for (int i = 0; i < RANDOM_OPS; i++) begin
			t = tag_t'(22'h200 + $urandom_range(4, 0));
			idx = index_t'(4 + $urandom_range(3, 0));
			run_access($sformatf("random access %0d", i), $urandom_range(1, 0) == 1,
				make_addr(t, idx, word_sel_t'($urandom_range(7, 0))),
				{$urandom, $urandom}, byte_en_t'($urandom), lat);
		end

		@(posedge clk);
		#1;
		checks++;
		if (name_q.size() != 0 || wb_q.size() != 0) begin
			errors++;
			$display("expected results still pending at the end of the run");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* filelist.f */
rtl/dcache_pkg.sv
rtl/tag_state_array.sv
rtl/line_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/dcache_assertions.sv
testbench/tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dcache
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?=

COMMON = --timing --timescale $(TIMESCALE) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(COMMON)

sim:
	$(VERILATOR) --binary $(COMMON) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
